/* hdl/decodePkg.sv */
// Shared widths, field positions and decode enums, used by scoped name in the decode RTL and testbench
package decodePkg;

    localparam int dataWidth = 16;
    localparam int regCount = 8;
    localparam int regSelWidth = 3;
    localparam int wbDelay = 3;

    // Instruction field positions
    localparam int opHi = 15;
    localparam int opLo = 11;
    localparam int rsHi = 10;
    localparam int rsLo = 8;
    localparam int rtHi = 7;
    localparam int rtLo = 5;
    localparam int rdRHi = 4;
    localparam int rdRLo = 2;
    localparam int functHi = 1;
    localparam int functLo = 0;
    localparam int imm5Width = 5;
    localparam int imm8Width = 8;
    localparam int imm11Width = 11;

    // Link register written by JAL and JALR
    localparam int linkReg = 7;

    // Opcodes in instr[15:11], grouped by family
    typedef enum logic [4:0] {
        HALT = 5'b00000, NOP = 5'b00001,
        J = 5'b00100, JR = 5'b00101, JAL = 5'b00110, JALR = 5'b00111,
        ADDI = 5'b01000, SUBI = 5'b01001, XORI = 5'b01010, ANDNI = 5'b01011,
        BEQZ = 5'b01100, BNEZ = 5'b01101, BLTZ = 5'b01110, BGEZ = 5'b01111,
        ST = 5'b10000, LD = 5'b10001, SLBI = 5'b10010,
        ROLI = 5'b10100, SLLI = 5'b10101, RORI = 5'b10110, SRLI = 5'b10111,
        LBI = 5'b11000, RSHIFT = 5'b11010, RARITH = 5'b11011,
        SEQ = 5'b11100, SLT = 5'b11101, SLE = 5'b11110, SCO = 5'b11111
    } opcodeE;

    typedef enum logic [2:0] {
        addClass, subClass, xorClass, andnClass,
        shiftImmClass, shiftRegClass, compareClass, passClass
    } aluClassE;

    typedef enum logic [3:0] {
        add = 4'd0, sub = 4'd1, xorOp = 4'd2, andn = 4'd3,
        rol = 4'd4, sll = 4'd5, ror = 4'd6, srl = 4'd7,
        seq = 4'd8, slt = 4'd9, sle = 4'd10, sco = 4'd11,
        passB = 4'd12, lbiShift = 4'd13
    } aluOpE;

    typedef enum logic [1:0] {rdFromI1, rdFromRs, rdFromR, rdLink} regDstE;

    typedef enum logic [2:0] {none, beqz, bnez, bltz, bgez, jumpImm, jumpReg} branchKindE;

endpackage

/* hdl/instrControl.sv */
// Main opcode decoder of the decode stage; turns the opcode into control levels and flags illegal ones
`timescale 1ns/1ns

module instrControl (
    input  decodePkg::opcodeE    opcode,
    output decodePkg::regDstE    regDst,
    output logic                 regWrite,
    output logic                 zeroExt,
    output logic                 memRead,
    output logic                 memWrite,
    output logic                 immSel,
    output logic [1:0]           bSrc,
    output logic [1:0]           regSrc,
    output decodePkg::aluClassE  aluClass,
    output logic                 aluSigned,
    output logic                 aluJump,
    output decodePkg::branchKindE branchKind,
    output logic                 haltN,
    output logic                 nop,
    output logic                 err
);

    // bSrc: 00 rt, 01 imm5, 10 imm8
    // regSrc: 00 ALU result, 01 load data, 10 link address
    always_comb begin
        regDst = decodePkg::rdFromI1;
        regWrite = 1'b0;
        zeroExt = 1'b0;
        memRead = 1'b0;
        memWrite = 1'b0;
        immSel = 1'b0;
        bSrc = 2'b00;
        regSrc = 2'b00;
        aluClass = decodePkg::passClass;
        aluSigned = 1'b0;
        aluJump = 1'b0;
        branchKind = decodePkg::none;
        haltN = 1'b1;
        nop = 1'b0;
        err = 1'b0;

        case (opcode)
            decodePkg::HALT: haltN = 1'b0;
            decodePkg::NOP: nop = 1'b1;
            decodePkg::ADDI, decodePkg::SUBI, decodePkg::XORI, decodePkg::ANDNI: begin
                regWrite = 1'b1;
                bSrc = 2'b01;
                // Logic immediates are zero extended
                zeroExt = (opcode == decodePkg::XORI) || (opcode == decodePkg::ANDNI);
                case (opcode)
                    decodePkg::ADDI: aluClass = decodePkg::addClass;
                    decodePkg::SUBI: aluClass = decodePkg::subClass;
                    decodePkg::XORI: aluClass = decodePkg::xorClass;
                    default: aluClass = decodePkg::andnClass;
                endcase
            end
            decodePkg::ROLI, decodePkg::SLLI, decodePkg::RORI, decodePkg::SRLI: begin
                regWrite = 1'b1;
                bSrc = 2'b01;
                aluClass = decodePkg::shiftImmClass;
            end
            decodePkg::ST: begin
                memWrite = 1'b1;
                bSrc = 2'b01;
                aluClass = decodePkg::addClass;
            end
            decodePkg::LD: begin
                memRead = 1'b1;
                regWrite = 1'b1;
                regSrc = 2'b01;
                bSrc = 2'b01;
                aluClass = decodePkg::addClass;
            end
            decodePkg::LBI, decodePkg::SLBI: begin
                regWrite = 1'b1;
                regDst = decodePkg::rdFromRs;
                bSrc = 2'b10;
            end
            decodePkg::RARITH, decodePkg::RSHIFT: begin
                regWrite = 1'b1;
                regDst = decodePkg::rdFromR;
                aluClass = (opcode == decodePkg::RARITH) ? decodePkg::addClass
                                                         : decodePkg::shiftRegClass;
            end
            decodePkg::SEQ, decodePkg::SLT, decodePkg::SLE, decodePkg::SCO: begin
                regWrite = 1'b1;
                regDst = decodePkg::rdFromR;
                aluClass = decodePkg::compareClass;
                aluSigned = (opcode == decodePkg::SLT) || (opcode == decodePkg::SLE);
            end
            decodePkg::BEQZ: branchKind = decodePkg::beqz;
            decodePkg::BNEZ: branchKind = decodePkg::bnez;
            decodePkg::BLTZ: branchKind = decodePkg::bltz;
            decodePkg::BGEZ: branchKind = decodePkg::bgez;
            decodePkg::J, decodePkg::JAL: begin
                branchKind = decodePkg::jumpImm;
                immSel = 1'b1;
                regWrite = (opcode == decodePkg::JAL);
                regDst = decodePkg::rdLink;
                regSrc = 2'b10;
            end
            decodePkg::JR, decodePkg::JALR: begin
                // Target is rs plus the sign-extended imm8, formed in the ALU
                branchKind = decodePkg::jumpReg;
                aluJump = 1'b1;
                aluClass = decodePkg::addClass;
                bSrc = 2'b10;
                regWrite = (opcode == decodePkg::JALR);
                regDst = decodePkg::rdLink;
                regSrc = 2'b10;
            end
            default: err = 1'b1;
        endcase
    end

endmodule

/* hdl/aluControl.sv */
// ALU control; expands the decoded operation class and function bits into the final ALU operation
`timescale 1ns/1ns

module aluControl (
    input  decodePkg::aluClassE aluClass,
    input  logic [1:0]          funct,
    output decodePkg::aluOpE    aluOp,
    output logic                invA,
    output logic                invB,
    output logic                carryIn
);

    always_comb begin
        aluOp = decodePkg::passB;
        invA = 1'b0;
        invB = 1'b0;
        carryIn = 1'b0;

        case (aluClass)
            decodePkg::addClass: begin
                case (funct)
                    2'b00: aluOp = decodePkg::add;
                    2'b01: begin
                        aluOp = decodePkg::sub;
                        invB = 1'b1;
                        carryIn = 1'b1;
                    end
                    2'b10: aluOp = decodePkg::xorOp;
                    default: begin
                        aluOp = decodePkg::andn;
                        invB = 1'b1;
                    end
                endcase
            end
            // Immediate minus rs
            decodePkg::subClass: begin
                aluOp = decodePkg::sub;
                invA = 1'b1;
                carryIn = 1'b1;
            end
            decodePkg::xorClass: aluOp = decodePkg::xorOp;
            decodePkg::andnClass: begin
                aluOp = decodePkg::andn;
                invB = 1'b1;
            end
            decodePkg::shiftImmClass, decodePkg::shiftRegClass: begin
                case (funct)
                    2'b00: aluOp = decodePkg::rol;
                    2'b01: aluOp = decodePkg::sll;
                    2'b10: aluOp = decodePkg::ror;
                    default: aluOp = decodePkg::srl;
                endcase
            end
            decodePkg::compareClass: begin
                // SCO uses the carry out of a plain add, the rest subtract
                invB = (funct != 2'b11);
                carryIn = (funct != 2'b11);
                case (funct)
                    2'b00: aluOp = decodePkg::seq;
                    2'b01: aluOp = decodePkg::slt;
                    2'b10: aluOp = decodePkg::sle;
                    default: aluOp = decodePkg::sco;
                endcase
            end
            default: aluOp = (funct == 2'b10) ? decodePkg::lbiShift : decodePkg::passB;
        endcase
    end

endmodule

/* hdl/regFileBypass.sv */
// Eight-entry register file with two read ports, one write port and same-cycle write-to-read bypass
`timescale 1ns/1ns

module regFileBypass (
    input  logic                              clk,
    input  logic                              arstN,
    input  logic [decodePkg::regSelWidth-1:0] read1Sel,
    input  logic [decodePkg::regSelWidth-1:0] read2Sel,
    input  logic [decodePkg::regSelWidth-1:0] writeSel,
    input  logic [decodePkg::dataWidth-1:0]   writeData,
    input  logic                              writeEn,
    output logic [decodePkg::dataWidth-1:0]   read1Data,
    output logic [decodePkg::dataWidth-1:0]   read2Data
);

    logic [decodePkg::dataWidth-1:0] regs [decodePkg::regCount];
    logic hit1;
    logic hit2;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < decodePkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeSel] <= writeData;
        end
    end

    // Write in flight to the same register wins
    assign hit1 = writeEn && (read1Sel == writeSel);
    assign hit2 = writeEn && (read2Sel == writeSel);

    assign read1Data = hit1 ? writeData : regs[read1Sel];
    assign read2Data = hit2 ? writeData : regs[read2Sel];

endmodule

/* hdl/decodeStage.sv */
// Top of the decode stage; decodes instr, extends immediates, reads operands and delays the WB target
`timescale 1ns/1ns

module decodeStage (
    input  logic                               clk,
    input  logic                               arstN,
    input  logic [decodePkg::dataWidth-1:0]    instr,
    input  logic [decodePkg::dataWidth-1:0]    writeData,
    input  logic                               nopInsert,
    output logic                               valid,
    output logic                               haltN,
    output logic                               memRead,
    output logic                               memWrite,
    output logic                               immSel,
    output logic                               aluSigned,
    output logic                               aluJump,
    output logic                               regWrite,
    output logic [1:0]                         regSrc,
    output logic [1:0]                         bSrc,
    output decodePkg::branchKindE              branchKind,
    output logic                               branchFlush,
    output decodePkg::aluOpE                   aluOp,
    output logic                               invA,
    output logic                               invB,
    output logic                               carryIn,
    output logic [decodePkg::dataWidth-1:0]    rsData,
    output logic [decodePkg::dataWidth-1:0]    rtData,
    output logic [decodePkg::dataWidth-1:0]    imm5,
    output logic [decodePkg::dataWidth-1:0]    imm8,
    output logic [decodePkg::dataWidth-1:0]    sImm8,
    output logic [decodePkg::dataWidth-1:0]    sImm11,
    output logic [decodePkg::regSelWidth-1:0]  rd,
    output logic [decodePkg::regSelWidth-1:0]  rdStage1,
    output logic [decodePkg::regSelWidth-1:0]  rdStage2,
    output logic                               regWriteStage1,
    output logic                               regWriteStage2,
    output logic                               nop,
    output logic                               err
);

    localparam int extImm5 = decodePkg::dataWidth - decodePkg::imm5Width;
    localparam int extImm8 = decodePkg::dataWidth - decodePkg::imm8Width;
    localparam int extImm11 = decodePkg::dataWidth - decodePkg::imm11Width;

    decodePkg::opcodeE opcodeSel;
    decodePkg::regDstE regDst;
    decodePkg::aluClassE aluClass;
    logic [decodePkg::opHi-decodePkg::opLo:0] opBits;
    logic [1:0] funct;
    logic zeroExt;
    logic regWriteDec;
    logic rstFlop;
    logic [decodePkg::regSelWidth-1:0] rdDec;
    logic [decodePkg::regSelWidth-1:0] rdPipe [decodePkg::wbDelay];
    logic [decodePkg::wbDelay-1:0] wePipe;

    // Hazard unit bubble replaces the opcode
    assign opcodeSel = nopInsert ? decodePkg::NOP
                                 : decodePkg::opcodeE'(instr[decodePkg::opHi:decodePkg::opLo]);
    assign opBits = opcodeSel;

    instrControl control (
        .opcode(opcodeSel), .regDst(regDst), .regWrite(regWriteDec), .zeroExt(zeroExt),
        .memRead(memRead), .memWrite(memWrite), .immSel(immSel), .bSrc(bSrc),
        .regSrc(regSrc), .aluClass(aluClass), .aluSigned(aluSigned), .aluJump(aluJump),
        .branchKind(branchKind), .haltN(haltN), .nop(nop), .err(err)
    );

    // Function bits from the R-format field, else from the low opcode bits where they select
    always_comb begin
        if (opcodeSel == decodePkg::RARITH || opcodeSel == decodePkg::RSHIFT) begin
            funct = instr[decodePkg::functHi:decodePkg::functLo];
        end else if (aluClass == decodePkg::shiftImmClass || aluClass == decodePkg::compareClass
                     || opcodeSel == decodePkg::SLBI) begin
            funct = opBits[1:0];
        end else begin
            funct = 2'b00;
        end
    end

    aluControl aluCtrl (
        .aluClass(aluClass), .funct(funct), .aluOp(aluOp),
        .invA(invA), .invB(invB), .carryIn(carryIn)
    );

    always_comb begin
        case (regDst)
            decodePkg::rdFromI1: rdDec = instr[decodePkg::rtHi:decodePkg::rtLo];
            decodePkg::rdFromRs: rdDec = instr[decodePkg::rsHi:decodePkg::rsLo];
            decodePkg::rdFromR: rdDec = instr[decodePkg::rdRHi:decodePkg::rdRLo];
            default: rdDec = decodePkg::regSelWidth'(decodePkg::linkReg);
        endcase
    end

    // Write-back target travels alongside the instruction to the end of the pipe
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < decodePkg::wbDelay; i++) begin
                rdPipe[i] <= '0;
            end
            wePipe <= '0;
        end else begin
            rdPipe[0] <= rdDec;
            wePipe[0] <= regWriteDec;
            for (int i = 1; i < decodePkg::wbDelay; i++) begin
                rdPipe[i] <= rdPipe[i-1];
                wePipe[i] <= wePipe[i-1];
            end
        end
    end

    assign rdStage1 = rdPipe[0];
    assign rdStage2 = rdPipe[1];
    assign rd = rdPipe[decodePkg::wbDelay-1];
    assign regWriteStage1 = wePipe[0];
    assign regWriteStage2 = wePipe[1];
    assign regWrite = wePipe[decodePkg::wbDelay-1];

    regFileBypass regFile (
        .clk(clk), .arstN(arstN),
        .read1Sel(instr[decodePkg::rsHi:decodePkg::rsLo]),
        .read2Sel(instr[decodePkg::rtHi:decodePkg::rtLo]),
        .writeSel(rd), .writeData(writeData), .writeEn(regWrite),
        .read1Data(rsData), .read2Data(rtData)
    );

    assign sImm8 = {{extImm8{instr[decodePkg::imm8Width-1]}}, instr[decodePkg::imm8Width-1:0]};
    assign sImm11 = {{extImm11{instr[decodePkg::imm11Width-1]}},
                     instr[decodePkg::imm11Width-1:0]};
    assign imm8 = zeroExt ? {{extImm8{1'b0}}, instr[decodePkg::imm8Width-1:0]} : sImm8;
    assign imm5 = zeroExt ? {{extImm5{1'b0}}, instr[decodePkg::imm5Width-1:0]}
                          : {{extImm5{instr[decodePkg::imm5Width-1]}},
                             instr[decodePkg::imm5Width-1:0]};

    assign branchFlush = (branchKind == decodePkg::jumpImm) || (branchKind == decodePkg::jumpReg);

    // Registered copy of reset, so valid rises one edge after release
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rstFlop <= 1'b1;
        end else begin
            rstFlop <= 1'b0;
        end
    end

    assign valid = ~rstFlop;

endmodule

/* dv/decodeModel.svh */
// Reference decode rules for the decode-stage testbench, pulled into the testbench module by include
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

function automatic logic legalOpcode(input logic [4:0] op);
    case (decodePkg::opcodeE'(op))
        decodePkg::HALT, decodePkg::NOP, decodePkg::J, decodePkg::JR, decodePkg::JAL,
        decodePkg::JALR, decodePkg::ADDI, decodePkg::SUBI, decodePkg::XORI, decodePkg::ANDNI,
        decodePkg::BEQZ, decodePkg::BNEZ, decodePkg::BLTZ, decodePkg::BGEZ, decodePkg::ST,
        decodePkg::LD, decodePkg::SLBI, decodePkg::ROLI, decodePkg::SLLI, decodePkg::RORI,
        decodePkg::SRLI, decodePkg::LBI, decodePkg::RSHIFT, decodePkg::RARITH, decodePkg::SEQ,
        decodePkg::SLT, decodePkg::SLE, decodePkg::SCO: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

function automatic logic writesReg(input logic [4:0] op);
    case (decodePkg::opcodeE'(op))
        decodePkg::ADDI, decodePkg::SUBI, decodePkg::XORI, decodePkg::ANDNI,
        decodePkg::ROLI, decodePkg::SLLI, decodePkg::RORI, decodePkg::SRLI,
        decodePkg::LD, decodePkg::LBI, decodePkg::SLBI, decodePkg::RARITH, decodePkg::RSHIFT,
        decodePkg::SEQ, decodePkg::SLT, decodePkg::SLE, decodePkg::SCO,
        decodePkg::JAL, decodePkg::JALR: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

// Only the logic immediates are zero filled
function automatic logic zeroExtends(input logic [4:0] op);
    return (op == decodePkg::XORI) || (op == decodePkg::ANDNI);
endfunction

function automatic logic [2:0] destReg(input logic [4:0] op, input logic [15:0] word);
    case (decodePkg::opcodeE'(op))
        decodePkg::LBI, decodePkg::SLBI: return word[10:8];
        decodePkg::RARITH, decodePkg::RSHIFT, decodePkg::SEQ, decodePkg::SLT,
        decodePkg::SLE, decodePkg::SCO: return word[4:2];
        // Link register
        decodePkg::J, decodePkg::JR, decodePkg::JAL, decodePkg::JALR: return 3'd7;
        default: return word[7:5];
    endcase
endfunction

function automatic logic [2:0] branchOf(input logic [4:0] op);
    case (decodePkg::opcodeE'(op))
        decodePkg::BEQZ: return decodePkg::beqz;
        decodePkg::BNEZ: return decodePkg::bnez;
        decodePkg::BLTZ: return decodePkg::bltz;
        decodePkg::BGEZ: return decodePkg::bgez;
        decodePkg::J, decodePkg::JAL: return decodePkg::jumpImm;
        decodePkg::JR, decodePkg::JALR: return decodePkg::jumpReg;
        default: return decodePkg::none;
    endcase
endfunction

// Packed as {immSel, aluSigned, aluJump, regSrc, bSrc}
// bSrc 00 rt, 01 imm5, 10 imm8; regSrc 00 ALU, 01 load, 10 link
function automatic logic [6:0] operandCtrlOf(input logic [4:0] op);
    case (decodePkg::opcodeE'(op))
        decodePkg::ADDI, decodePkg::SUBI, decodePkg::XORI, decodePkg::ANDNI,
        decodePkg::ROLI, decodePkg::SLLI, decodePkg::RORI, decodePkg::SRLI,
        decodePkg::ST: return 7'b000_00_01;
        decodePkg::LD: return 7'b000_01_01;
        decodePkg::LBI, decodePkg::SLBI: return 7'b000_00_10;
        decodePkg::SLT, decodePkg::SLE: return 7'b010_00_00;
        decodePkg::J, decodePkg::JAL: return 7'b100_10_00;
        decodePkg::JR, decodePkg::JALR: return 7'b001_10_10;
        default: return 7'b000_00_00;
    endcase
endfunction

// Packed as {aluOp, invA, invB, carryIn}
function automatic logic [6:0] aluCtrlOf(input logic [4:0] op, input logic [1:0] funct);
    case (decodePkg::opcodeE'(op))
        decodePkg::ADDI, decodePkg::ST, decodePkg::LD, decodePkg::JR, decodePkg::JALR:
            return {decodePkg::add, 3'b000};
        decodePkg::SUBI: return {decodePkg::sub, 3'b101};
        decodePkg::XORI: return {decodePkg::xorOp, 3'b000};
        decodePkg::ANDNI: return {decodePkg::andn, 3'b010};
        decodePkg::ROLI: return {decodePkg::rol, 3'b000};
        decodePkg::SLLI: return {decodePkg::sll, 3'b000};
        decodePkg::RORI: return {decodePkg::ror, 3'b000};
        decodePkg::SRLI: return {decodePkg::srl, 3'b000};
        decodePkg::SLBI: return {decodePkg::lbiShift, 3'b000};
        decodePkg::SEQ: return {decodePkg::seq, 3'b011};
        decodePkg::SLT: return {decodePkg::slt, 3'b011};
        decodePkg::SLE: return {decodePkg::sle, 3'b011};
        decodePkg::SCO: return {decodePkg::sco, 3'b000};
        decodePkg::RARITH: begin
            case (funct)
                2'b00: return {decodePkg::add, 3'b000};
                2'b01: return {decodePkg::sub, 3'b011};
                2'b10: return {decodePkg::xorOp, 3'b000};
                default: return {decodePkg::andn, 3'b010};
            endcase
        end
        decodePkg::RSHIFT: begin
            case (funct)
                2'b00: return {decodePkg::rol, 3'b000};
                2'b01: return {decodePkg::sll, 3'b000};
                2'b10: return {decodePkg::ror, 3'b000};
                default: return {decodePkg::srl, 3'b000};
            endcase
        end
        default: return {decodePkg::passB, 3'b000};
    endcase
endfunction

// Low width bits kept, upper bits filled with zero or the field's top bit
function automatic logic [15:0] extendField(input logic [15:0] word, input int width,
                                            input logic zeroFill);
    logic [15:0] result;
    result = word;
    for (int i = width; i < 16; i++) begin
        result[i] = zeroFill ? 1'b0 : word[width-1];
    end
    return result;
endfunction

`endif

/* dv/decodeTb.sv */
// Self-checking testbench for the decode stage; random instructions compared with a reference model
`timescale 1ns/1ns

module decodeTb;

    localparam int numCycles = 2000;
    localparam int resetTimeout = 40;

    logic clk;
    logic arstN;
    logic [decodePkg::dataWidth-1:0] instr;
    logic [decodePkg::dataWidth-1:0] writeData;
    logic nopInsert;
    logic valid;
    logic haltN;
    logic memRead;
    logic memWrite;
    logic immSel;
    logic aluSigned;
    logic aluJump;
    logic regWrite;
    logic [1:0] regSrc;
    logic [1:0] bSrc;
    decodePkg::branchKindE branchKind;
    logic branchFlush;
    decodePkg::aluOpE aluOp;
    logic invA;
    logic invB;
    logic carryIn;
    logic [decodePkg::dataWidth-1:0] rsData;
    logic [decodePkg::dataWidth-1:0] rtData;
    logic [decodePkg::dataWidth-1:0] imm5;
    logic [decodePkg::dataWidth-1:0] imm8;
    logic [decodePkg::dataWidth-1:0] sImm8;
    logic [decodePkg::dataWidth-1:0] sImm11;
    logic [decodePkg::regSelWidth-1:0] rd;
    logic [decodePkg::regSelWidth-1:0] rdStage1;
    logic [decodePkg::regSelWidth-1:0] rdStage2;
    logic regWriteStage1;
    logic regWriteStage2;
    logic nop;
    logic err;

    // Model state: register array and the write-back delay line
    logic [decodePkg::dataWidth-1:0] modelRegs [decodePkg::regCount];
    logic [decodePkg::regSelWidth-1:0] rdQ [decodePkg::wbDelay];
    logic [decodePkg::wbDelay-1:0] weQ;
    logic [4:0] curOp;
    logic [decodePkg::regSelWidth-1:0] rdCur;
    logic weCur;
    integer seed;
    int errors;
    int timeouts;

    `include "decodeModel.svh"

    decodeStage DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        arstN = 1'b0;
        repeat (16) @(posedge clk);
        #1 arstN = 1'b1;
    end

    task automatic checkValue(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s: expected 0x%h, actual 0x%h at %0t", name, expected, actual, $time);
        end
    endtask

    // Effective opcode and write-back target of the instruction now on instr
    task automatic predictDecode();
        if (nopInsert) begin
            curOp = decodePkg::NOP;
        end else begin
            curOp = instr[15:11];
        end
        rdCur = destReg(curOp, instr);
        weCur = writesReg(curOp);
    endtask

    // Called right after a rising edge, before inputs change
    task automatic advanceModel();
        if (weQ[2]) begin
            modelRegs[rdQ[2]] = writeData;
        end
        rdQ[2] = rdQ[1];
        rdQ[1] = rdQ[0];
        rdQ[0] = rdCur;
        weQ = {weQ[1:0], weCur};
    endtask

    task automatic driveStimulus();
        logic [31:0] rnd;
        rnd = $random(seed);
        instr = rnd[15:0];
        rnd = $random(seed);
        writeData = rnd[15:0];
        // Roughly one bubble every eight cycles
        nopInsert = (rnd[18:16] == 3'b000);
        predictDecode();
    endtask

    task automatic checkResetState();
        checkValue("resetValid", 16'(1'b0), 16'(valid));
        checkValue("resetRd", 16'(3'd0), 16'(rd));
        checkValue("resetRegWrite", 16'(1'b0), 16'(regWrite));
        checkValue("resetRdStage1", 16'(3'd0), 16'(rdStage1));
        checkValue("resetRdStage2", 16'(3'd0), 16'(rdStage2));
        checkValue("resetRegWriteStage1", 16'(1'b0), 16'(regWriteStage1));
        checkValue("resetRegWriteStage2", 16'(1'b0), 16'(regWriteStage2));
    endtask

    task automatic checkOutputs();
        logic [6:0] alu;
        logic [6:0] operand;
        logic [2:0] branch;
        logic zero;
        logic [2:0] rs;
        logic [2:0] rt;
        alu = aluCtrlOf(curOp, instr[1:0]);
        operand = operandCtrlOf(curOp);
        branch = branchOf(curOp);
        zero = zeroExtends(curOp);
        rs = instr[10:8];
        rt = instr[7:5];
        checkValue("valid", 16'(1'b1), 16'(valid));
        checkValue("memRead", 16'(curOp == decodePkg::LD), 16'(memRead));
        checkValue("memWrite", 16'(curOp == decodePkg::ST), 16'(memWrite));
        checkValue("haltN", 16'(curOp != decodePkg::HALT), 16'(haltN));
        checkValue("nop", 16'(curOp == decodePkg::NOP), 16'(nop));
        checkValue("err", 16'(!legalOpcode(curOp)), 16'(err));
        checkValue("branchKind", 16'(branch), 16'(branchKind));
        checkValue("branchFlush",
                   16'(branch == decodePkg::jumpImm || branch == decodePkg::jumpReg),
                   16'(branchFlush));
        checkValue("immSel", 16'(operand[6]), 16'(immSel));
        checkValue("aluSigned", 16'(operand[5]), 16'(aluSigned));
        checkValue("aluJump", 16'(operand[4]), 16'(aluJump));
        checkValue("regSrc", 16'(operand[3:2]), 16'(regSrc));
        checkValue("bSrc", 16'(operand[1:0]), 16'(bSrc));
        checkValue("aluOp", 16'(alu[6:3]), 16'(aluOp));
        checkValue("invA", 16'(alu[2]), 16'(invA));
        checkValue("invB", 16'(alu[1]), 16'(invB));
        checkValue("carryIn", 16'(alu[0]), 16'(carryIn));
        checkValue("imm5", extendField(instr, 5, zero), imm5);
        checkValue("imm8", extendField(instr, 8, zero), imm8);
        checkValue("sImm8", extendField(instr, 8, 1'b0), sImm8);
        checkValue("sImm11", extendField(instr, 11, 1'b0), sImm11);
        checkValue("rdStage1", 16'(rdQ[0]), 16'(rdStage1));
        checkValue("regWriteStage1", 16'(weQ[0]), 16'(regWriteStage1));
        checkValue("rdStage2", 16'(rdQ[1]), 16'(rdStage2));
        checkValue("regWriteStage2", 16'(weQ[1]), 16'(regWriteStage2));
        checkValue("rd", 16'(rdQ[2]), 16'(rd));
        checkValue("regWrite", 16'(weQ[2]), 16'(regWrite));
        // Write-back in the same cycle is forwarded to the read ports
        checkValue("rsData", (weQ[2] && rs == rdQ[2]) ? writeData : modelRegs[rs], rsData);
        checkValue("rtData", (weQ[2] && rt == rdQ[2]) ? writeData : modelRegs[rt], rtData);
    endtask

    initial begin
        int waited;
        seed = 95025;
        errors = 0;
        timeouts = 0;
        // ADDI targeting r7 held on instr through reset
        instr = 16'h40E0;
        writeData = '0;
        nopInsert = 1'b0;
        weQ = '0;
        for (int i = 0; i < decodePkg::wbDelay; i++) begin
            rdQ[i] = '0;
        end
        for (int i = 0; i < decodePkg::regCount; i++) begin
            modelRegs[i] = '0;
        end
        predictDecode();
        repeat (3) begin
            @(posedge clk);
            #2;
            checkResetState();
        end
        waited = 0;
        while (arstN !== 1'b1 && waited < resetTimeout) begin
            @(posedge clk);
            waited++;
        end
        if (arstN !== 1'b1) begin
            timeouts++;
            $display("ERROR: reset was not released within %0d cycles", resetTimeout);
        end else begin
            for (int cycle = 0; cycle < numCycles; cycle++) begin
                advanceModel();
                #1;
                driveStimulus();
                #4;
                checkOutputs();
                @(posedge clk);
            end
        end
        $display("Decode checks finished: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* decode.f */
+incdir+dv
hdl/decodePkg.sv
hdl/instrControl.sv
hdl/aluControl.sv
hdl/regFileBypass.sv
hdl/decodeStage.sv
dv/decodeTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns --top-module decodeTb -f decode.f -o decodeSim
./obj_dir/decodeSim | tee sim.log

if grep -q "^STATUS: PASS$" sim.log; then
    exit 0
else
    exit 1
fi
